/* include/mdu_cfg.svh */
// --------------------------------------------------
// MDU configuration
// Operand width, multiplier unroll factor and
// step counter width for the multiply/divide unit
// --------------------------------------------------

`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// Operand and result width
`define MDU_XLEN        64

// Multiplier bits per cycle, must divide 32
`define MDU_MUL_UNROLL  4

// Wide enough for 64 divide steps
`define MDU_CTR_W       7

`endif

/* verilog/mdu_pkg.sv */
// --------------------------------------------------
// MDU package
// Shared types for the multiply/divide unit
// --------------------------------------------------

`include "mdu_cfg.svh"

package mdu_pkg;

    typedef logic [`MDU_XLEN-1:0]   xlen_t;     // One operand or result
    typedef logic [2*`MDU_XLEN-1:0] dxlen_t;    // Double width accumulator
    typedef logic [`MDU_CTR_W-1:0]  step_ctr_t; // Remaining iterations

    // Request as presented by the pipeline
    typedef struct packed {
        logic  op_word;   // 32-bit data, result sign extended
        logic  op_mul;
        logic  op_mulh;
        logic  op_mulhu;
        logic  op_mulhsu;
        logic  op_div;
        logic  op_divu;
        logic  op_rem;
        logic  op_remu;
        xlen_t rs1;
        xlen_t rs2;
    } mdu_req_t;

    // Decoded command, held for the whole operation
    typedef struct packed {
        logic word;
        logic is_div;
        logic lhs_signed;
        logic rhs_signed;
        logic hi;         // Upper half of product
        logic rem;        // Remainder, not quotient
    } mdu_cmd_t;

    typedef enum logic [1:0] {
        MDU_IDLE,
        MDU_MUL_RUN,
        MDU_DIV_RUN,
        MDU_DONE
    } mdu_state_e;

endpackage

/* verilog/mdu_ctrl.sv */
// --------------------------------------------------
// MDU control
// Decodes the request, sequences the iterations of
// the selected datapath and returns its result
// --------------------------------------------------

`timescale 1ns/1ps

`include "mdu_cfg.svh"

module mdu_ctrl (
    input  logic              g_clk,
    input  logic              arst_n,
    input  logic              valid,
    input  logic              flush,
    input  mdu_pkg::mdu_req_t req,
    input  mdu_pkg::xlen_t    mul_result,
    input  mdu_pkg::xlen_t    div_result,
    output mdu_pkg::mdu_cmd_t cmd,
    output logic              start,
    output logic              step,
    output logic              last,
    output logic              ready,
    output mdu_pkg::xlen_t    rd
);

    // Iteration counts per operation class
    localparam mdu_pkg::step_ctr_t MUL_STEPS   =
        mdu_pkg::step_ctr_t'(`MDU_XLEN / `MDU_MUL_UNROLL);
    localparam mdu_pkg::step_ctr_t MUL_STEPS_W =
        mdu_pkg::step_ctr_t'(32 / `MDU_MUL_UNROLL);
    localparam mdu_pkg::step_ctr_t DIV_STEPS   = mdu_pkg::step_ctr_t'(`MDU_XLEN);
    localparam mdu_pkg::step_ctr_t DIV_STEPS_W = mdu_pkg::step_ctr_t'(32);

    mdu_pkg::mdu_state_e state;
    mdu_pkg::step_ctr_t  ctr;
    mdu_pkg::step_ctr_t  ctr_init;
    mdu_pkg::mdu_cmd_t   dec;
    mdu_pkg::mdu_cmd_t   cmd_q;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------

    always_comb begin
        dec.word       = req.op_word;
        dec.is_div     = req.op_div | req.op_divu | req.op_rem | req.op_remu;
        dec.lhs_signed = req.op_mulh | req.op_mulhsu | req.op_div | req.op_rem;
        dec.rhs_signed = req.op_mulh | req.op_div | req.op_rem;
        dec.hi         = req.op_mulh | req.op_mulhu | req.op_mulhsu;
        dec.rem        = req.op_rem | req.op_remu;
    end

    always_comb begin
        if (dec.is_div) begin
            ctr_init = dec.word ? DIV_STEPS_W : DIV_STEPS;
        end else begin
            ctr_init = dec.word ? MUL_STEPS_W : MUL_STEPS;
        end
    end

    // Datapaths see the live decode on the start edge
    assign cmd = (state == mdu_pkg::MDU_IDLE) ? dec : cmd_q;

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------

    assign start = (state == mdu_pkg::MDU_IDLE) && valid && !flush;
    assign step  = (state == mdu_pkg::MDU_MUL_RUN) || (state == mdu_pkg::MDU_DIV_RUN);
    assign last  = step && (ctr == mdu_pkg::step_ctr_t'(1));

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mdu_pkg::MDU_IDLE;
            ctr   <= '0;
            cmd_q <= '0;
        end else if (flush) begin
            state <= mdu_pkg::MDU_IDLE;   // Abandon whatever is running
            ctr   <= '0;
        end else begin
            case (state)
                mdu_pkg::MDU_IDLE: begin
                    if (valid) begin
                        state <= dec.is_div ? mdu_pkg::MDU_DIV_RUN : mdu_pkg::MDU_MUL_RUN;
                        ctr   <= ctr_init;
                        cmd_q <= dec;
                    end
                end
                mdu_pkg::MDU_MUL_RUN,
                mdu_pkg::MDU_DIV_RUN: begin
                    ctr <= ctr - mdu_pkg::step_ctr_t'(1);
                    if (last) begin
                        state <= mdu_pkg::MDU_DONE;
                    end
                end
                mdu_pkg::MDU_DONE: begin
                    state <= mdu_pkg::MDU_DONE;   // Hold until flush
                end
                default: begin
                    state <= mdu_pkg::MDU_IDLE;
                end
            endcase
        end
    end

    // Result return
    assign ready = (state == mdu_pkg::MDU_DONE);
    assign rd    = cmd_q.is_div ? div_result : mul_result;

endmodule

/* verilog/mdu_mul_datapath.sv */
// --------------------------------------------------
// MDU multiplier datapath
// Shift-add multiply, MDU_MUL_UNROLL bits per step,
// with signed correction and result extraction
// --------------------------------------------------

`timescale 1ns/1ps

`include "mdu_cfg.svh"

module mdu_mul_datapath (
    input  logic              g_clk,
    input  logic              arst_n,
    input  mdu_pkg::mdu_cmd_t cmd,
    input  logic              start,
    input  logic              step,
    input  logic              last,
    input  mdu_pkg::xlen_t    rs1,
    input  mdu_pkg::xlen_t    rs2,
    output mdu_pkg::xlen_t    mul_result
);

    localparam int XLEN   = `MDU_XLEN;
    localparam int UNROLL = `MDU_MUL_UNROLL;

    mdu_pkg::xlen_t  mcand;     // Multiplicand, fixed for the operation
    mdu_pkg::xlen_t  mplier;    // Multiplier, consumed from the bottom
    mdu_pkg::dxlen_t acc;
    mdu_pkg::dxlen_t acc_nxt;

    logic            mul_step;
    logic            sub_bit;
    logic [XLEN:0]   addend;
    logic [XLEN:0]   hi_ext;
    logic [XLEN:0]   sum;

    assign mul_step = step && !cmd.is_div;

    // --------------------------------------------------
    // One step of UNROLL partial products
    // --------------------------------------------------

    always_comb begin
        acc_nxt = acc;
        sub_bit = 1'b0;
        addend  = '0;
        hi_ext  = '0;
        sum     = '0;
        for (int i = 0; i < UNROLL; i++) begin
            // Top bit of a signed multiplier has negative weight
            sub_bit = last && cmd.rhs_signed && (i == UNROLL - 1);
            addend  = mplier[i] ? {cmd.lhs_signed & mcand[XLEN-1], mcand} : '0;
            if (sub_bit) begin
                addend = -addend;
            end
            hi_ext  = {cmd.lhs_signed & acc_nxt[2*XLEN-1], acc_nxt[2*XLEN-1:XLEN]};
            sum     = hi_ext + addend;
            acc_nxt = {sum, acc_nxt[XLEN-1:1]};   // Arithmetic shift right by one
        end
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (start) begin
            mcand <= rs1;
        end
    end

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            acc    <= '0;
            mplier <= '0;
        end else if (start) begin
            acc    <= '0;
            mplier <= rs2;
        end else if (mul_step) begin
            acc    <= acc_nxt;
            mplier <= mplier >> UNROLL;
        end
    end

    // Word product ends up in the middle after 32 shifts
    always_comb begin
        if (cmd.word) begin
            mul_result = {{32{acc[XLEN-1]}}, acc[XLEN-1:32]};
        end else if (cmd.hi) begin
            mul_result = acc[2*XLEN-1:XLEN];
        end else begin
            mul_result = acc[XLEN-1:0];
        end
    end

endmodule

/* verilog/mdu_div_datapath.sv */
// --------------------------------------------------
// MDU divider datapath
// Restoring division on magnitudes, one quotient
// bit per step, signs applied on the way out
// --------------------------------------------------

`timescale 1ns/1ps

`include "mdu_cfg.svh"

module mdu_div_datapath (
    input  logic              g_clk,
    input  logic              arst_n,
    input  mdu_pkg::mdu_cmd_t cmd,
    input  logic              start,
    input  logic              step,
    input  mdu_pkg::xlen_t    rs1,
    input  mdu_pkg::xlen_t    rs2,
    output mdu_pkg::xlen_t    div_result
);

    localparam int XLEN = `MDU_XLEN;

    mdu_pkg::xlen_t  lhs_ext;
    mdu_pkg::xlen_t  rhs_ext;
    mdu_pkg::xlen_t  lhs_mag;
    mdu_pkg::xlen_t  rhs_mag;
    logic            lhs_neg;
    logic            rhs_neg;
    logic            rhs_nz;

    mdu_pkg::xlen_t  rem_q;       // Partial remainder
    mdu_pkg::xlen_t  quo_q;       // Quotient, built from the bottom
    mdu_pkg::dxlen_t divisor;     // Aligned divisor, moves right
    logic            lhs_neg_q;
    logic            rhs_neg_q;
    logic            rhs_nz_q;

    logic            div_step;
    logic            fits;
    logic            quo_neg;
    mdu_pkg::xlen_t  res_pre;

    // --------------------------------------------------
    // Operand preparation
    // --------------------------------------------------

    always_comb begin
        if (cmd.word) begin
            lhs_ext = {{32{cmd.lhs_signed & rs1[31]}}, rs1[31:0]};
            rhs_ext = {{32{cmd.rhs_signed & rs2[31]}}, rs2[31:0]};
            rhs_nz  = |rs2[31:0];
        end else begin
            lhs_ext = rs1;
            rhs_ext = rs2;
            rhs_nz  = |rs2;
        end
    end

    assign lhs_neg = cmd.lhs_signed & lhs_ext[XLEN-1];
    assign rhs_neg = cmd.rhs_signed & rhs_ext[XLEN-1];
    assign lhs_mag = lhs_neg ? -lhs_ext : lhs_ext;
    assign rhs_mag = rhs_neg ? -rhs_ext : rhs_ext;

    // --------------------------------------------------
    // Iteration
    // --------------------------------------------------

    assign div_step = step && cmd.is_div;
    assign fits     = divisor <= {{XLEN{1'b0}}, rem_q};

    always_ff @(posedge g_clk) begin
        if (start) begin
            rem_q   <= lhs_mag;
            quo_q   <= '0;
            // Divisor starts at weight 2^(n-1)
            divisor <= {{XLEN{1'b0}}, rhs_mag} << (cmd.word ? 31 : XLEN - 1);
        end else if (div_step) begin
            if (fits) begin
                rem_q <= rem_q - divisor[XLEN-1:0];
            end
            quo_q   <= {quo_q[XLEN-2:0], fits};
            divisor <= divisor >> 1;
        end
    end

    // Sign record of the operation
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            lhs_neg_q <= 1'b0;
            rhs_neg_q <= 1'b0;
            rhs_nz_q  <= 1'b0;
        end else if (start) begin
            lhs_neg_q <= lhs_neg;
            rhs_neg_q <= rhs_neg;
            rhs_nz_q  <= rhs_nz;
        end
    end

    // --------------------------------------------------
    // Sign fix-up
    // --------------------------------------------------

    // Divide by zero keeps all ones quotient positive
    assign quo_neg = (lhs_neg_q ^ rhs_neg_q) & rhs_nz_q;

    always_comb begin
        if (cmd.rem) begin
            res_pre = lhs_neg_q ? -rem_q : rem_q;   // Dividend sign
        end else begin
            res_pre = quo_neg ? -quo_q : quo_q;
        end
    end

    assign div_result = cmd.word ? {{32{res_pre[31]}}, res_pre[31:0]} : res_pre;

endmodule

/* verilog/core_pipe_exec_mdu.sv */
// --------------------------------------------------
// Execute stage multiply/divide unit
// Control with iterative multiplier and divider
// --------------------------------------------------

`timescale 1ns/1ps

module core_pipe_exec_mdu (
    input  logic              g_clk,
    input  logic              arst_n,
    input  logic              valid,
    input  logic              flush,
    input  mdu_pkg::mdu_req_t req,
    output logic              ready,
    output mdu_pkg::xlen_t    rd
);

    mdu_pkg::mdu_cmd_t cmd;
    logic              start;
    logic              step;
    logic              last;
    mdu_pkg::xlen_t    mul_result;
    mdu_pkg::xlen_t    div_result;

    mdu_ctrl i_ctrl (
        .g_clk      (g_clk),
        .arst_n     (arst_n),
        .valid      (valid),
        .flush      (flush),
        .req        (req),
        .mul_result (mul_result),
        .div_result (div_result),
        .cmd        (cmd),
        .start      (start),
        .step       (step),
        .last       (last),
        .ready      (ready),
        .rd         (rd)
    );

    mdu_mul_datapath i_mul (
        .g_clk      (g_clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .start      (start),
        .step       (step),
        .last       (last),
        .rs1        (req.rs1),
        .rs2        (req.rs2),
        .mul_result (mul_result)
    );

    mdu_div_datapath i_div (
        .g_clk      (g_clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .start      (start),
        .step       (step),
        .rs1        (req.rs1),
        .rs2        (req.rs2),
        .div_result (div_result)
    );

endmodule

/* verif/tb_mdu.sv */
// --------------------------------------------------
// MDU testbench
// Table driven checks of multiply, divide, hold
// and flush behavior against a reference model
// --------------------------------------------------

`timescale 1ns/1ps

`include "mdu_cfg.svh"

module tb_mdu;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_FIXED   = 24;
    localparam int NUM_RAND    = 48;
    localparam int NUM_VEC     = NUM_FIXED + NUM_RAND;
    localparam int READY_LIMIT = 200;              // Cycles per operation
    localparam int HOLD_CYCLES = 3;
    localparam int WATCHDOG_CYCLES = (NUM_VEC + 2) * 80 + 100;

    // Operation codes of the stimulus table
    localparam logic [2:0] OP_MUL    = 3'd0;
    localparam logic [2:0] OP_MULH   = 3'd1;
    localparam logic [2:0] OP_MULHU  = 3'd2;
    localparam logic [2:0] OP_MULHSU = 3'd3;
    localparam logic [2:0] OP_DIV    = 3'd4;
    localparam logic [2:0] OP_DIVU   = 3'd5;
    localparam logic [2:0] OP_REM    = 3'd6;
    localparam logic [2:0] OP_REMU   = 3'd7;

    localparam mdu_pkg::xlen_t ONES    = 64'hFFFF_FFFF_FFFF_FFFF;
    localparam mdu_pkg::xlen_t MIN_VAL = 64'h8000_0000_0000_0000;

    typedef struct packed {
        logic [2:0]     op;
        logic           word;
        mdu_pkg::xlen_t rs1;
        mdu_pkg::xlen_t rs2;
        mdu_pkg::xlen_t exp;
    } vec_t;

    logic              g_clk;
    logic              arst_n;
    logic              valid;
    logic              flush;
    mdu_pkg::mdu_req_t req;
    logic              ready;
    mdu_pkg::xlen_t    rd;

    vec_t   vec [NUM_VEC];
    integer seed = 32'hf153;
    int     errors = 0;
    int     timeouts = 0;

    core_pipe_exec_mdu i_dut (
        .g_clk  (g_clk),
        .arst_n (arst_n),
        .valid  (valid),
        .flush  (flush),
        .req    (req),
        .ready  (ready),
        .rd     (rd)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // --------------------------------------------------
    // Reference model and helpers
    // --------------------------------------------------

    function automatic mdu_pkg::xlen_t ref_result(input logic [2:0] op, input logic word,
                                                  input mdu_pkg::xlen_t a,
                                                  input mdu_pkg::xlen_t b);
        logic [127:0]       ea;
        logic [127:0]       eb;
        logic [127:0]       prod;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic               sgn;
        mdu_pkg::xlen_t     q;
        mdu_pkg::xlen_t     r;
        mdu_pkg::xlen_t     res;
        if (!op[2]) begin
            // Exact product of the operands extended by their signedness
            ea   = (op == OP_MULH || op == OP_MULHSU) ? {{64{a[63]}}, a} : {64'b0, a};
            eb   = (op == OP_MULH) ? {{64{b[63]}}, b} : {64'b0, b};
            prod = ea * eb;
            if (word) begin
                res = {{32{prod[31]}}, prod[31:0]};
            end else if (op == OP_MUL) begin
                res = prod[63:0];
            end else begin
                res = prod[127:64];
            end
        end else begin
            sgn = (op == OP_DIV) || (op == OP_REM);
            if (word) begin
                a = sgn ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]};
                b = sgn ? {{32{b[31]}}, b[31:0]} : {32'b0, b[31:0]};
            end
            sa = a;
            sb = b;
            if (b == '0) begin
                q = ONES;                               // Divide by zero
                r = a;
            end else if (sgn && a == MIN_VAL && b == ONES) begin
                q = a;                                  // Signed overflow
                r = '0;
            end else if (sgn) begin
                q = sa / sb;                            // Truncates toward zero
                r = sa % sb;
            end else begin
                q = a / b;
                r = a % b;
            end
            res = (op == OP_REM || op == OP_REMU) ? r : q;
            if (word) begin
                res = {{32{res[31]}}, res[31:0]};
            end
        end
        return res;
    endfunction

    function automatic mdu_pkg::mdu_req_t make_req(input logic [2:0] op, input logic word,
                                                   input mdu_pkg::xlen_t a,
                                                   input mdu_pkg::xlen_t b);
        mdu_pkg::mdu_req_t r;
        r         = '0;
        r.op_word = word;
        r.rs1     = a;
        r.rs2     = b;
        case (op)
            OP_MUL:    r.op_mul    = 1'b1;
            OP_MULH:   r.op_mulh   = 1'b1;
            OP_MULHU:  r.op_mulhu  = 1'b1;
            OP_MULHSU: r.op_mulhsu = 1'b1;
            OP_DIV:    r.op_div    = 1'b1;
            OP_DIVU:   r.op_divu   = 1'b1;
            OP_REM:    r.op_rem    = 1'b1;
            default:   r.op_remu   = 1'b1;
        endcase
        return r;
    endfunction

    function automatic vec_t make_vec(input logic [2:0] op, input logic word,
                                      input mdu_pkg::xlen_t a, input mdu_pkg::xlen_t b,
                                      input mdu_pkg::xlen_t exp);
        vec_t v;
        v.op   = op;
        v.word = word;
        v.rs1  = a;
        v.rs2  = b;
        v.exp  = exp;
        return v;
    endfunction

    task automatic check_value(input string what, input mdu_pkg::xlen_t got,
                               input mdu_pkg::xlen_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------

    task automatic load_fixed();
        vec[0]  = make_vec(OP_MUL,    0, 64'h0, ONES, 64'h0);
        vec[1]  = make_vec(OP_MUL,    0, ONES, ONES, 64'h1);
        vec[2]  = make_vec(OP_MULH,   0, ONES, ONES, 64'h0);
        vec[3]  = make_vec(OP_MULHU,  0, ONES, ONES, 64'hFFFF_FFFF_FFFF_FFFE);
        vec[4]  = make_vec(OP_MULHSU, 0, ONES, ONES, ONES);
        vec[5]  = make_vec(OP_MULH,   0, MIN_VAL, MIN_VAL, 64'h4000_0000_0000_0000);
        vec[6]  = make_vec(OP_MULH,   0, MIN_VAL, ONES, 64'h0);
        vec[7]  = make_vec(OP_MUL,    0, MIN_VAL, ONES, MIN_VAL);
        vec[8]  = make_vec(OP_MUL,    1, 64'hDEAD_BEEF_7FFF_FFFF, 64'h1234_5678_0000_0002,
                           64'hFFFF_FFFF_FFFF_FFFE);
        vec[9]  = make_vec(OP_DIV,    0, 64'h1234, 64'h0, ONES);
        vec[10] = make_vec(OP_DIVU,   0, 64'hFEDC_BA98_7654_3210, 64'h0, ONES);
        vec[11] = make_vec(OP_REM,    0, 64'hFFFF_FFFF_FFFF_FFF9, 64'h0, 64'hFFFF_FFFF_FFFF_FFF9);
        vec[12] = make_vec(OP_REMU,   0, 64'h8000_0000_0000_0005, 64'h0, 64'h8000_0000_0000_0005);
        vec[13] = make_vec(OP_DIV,    0, MIN_VAL, ONES, MIN_VAL);
        vec[14] = make_vec(OP_REM,    0, MIN_VAL, ONES, 64'h0);
        vec[15] = make_vec(OP_DIV,    1, 64'h0123_4567_89AB_CDEF, 64'hFFFF_FFFF_0000_0000, ONES);
        vec[16] = make_vec(OP_REM,    1, 64'hAAAA_AAAA_8000_0001, 64'h0000_0005_0000_0000,
                           64'hFFFF_FFFF_8000_0001);
        vec[17] = make_vec(OP_DIV,    1, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF,
                           64'hFFFF_FFFF_8000_0000);
        vec[18] = make_vec(OP_REM,    1, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF, 64'h0);
        vec[19] = make_vec(OP_DIV,    0, 64'hFFFF_FFFF_FFFF_FFF9, 64'h2, 64'hFFFF_FFFF_FFFF_FFFD);
        vec[20] = make_vec(OP_REM,    0, 64'hFFFF_FFFF_FFFF_FFF9, 64'h2, ONES);
        vec[21] = make_vec(OP_REM,    0, 64'h7, 64'hFFFF_FFFF_FFFF_FFFE, 64'h1);
        vec[22] = make_vec(OP_DIVU,   1, ONES, 64'hFFFF_FFFF_0000_0002, 64'h0000_0000_7FFF_FFFF);
        vec[23] = make_vec(OP_REMU,   1, 64'h9999_9999_0000_0007, 64'h3, 64'h1);
    endtask

    task automatic fill_random();
        logic [31:0] r;
        vec_t        v;
        for (int i = NUM_FIXED; i < NUM_VEC; i++) begin
            r      = $random(seed);
            v.op   = r[2:0];
            v.word = r[3] && (r[2:0] == OP_MUL || r[2]);   // No word form of MULH*
            v.rs1  = {$random(seed), $random(seed)};
            v.rs2  = {$random(seed), $random(seed)};
            if (r[4]) begin
                v.rs2 = v.rs2 >> r[10:5];                   // Smaller divisors too
            end
            if (r[13:11] == 3'd0) begin
                v.rs1 = MIN_VAL;
            end else if (r[13:11] == 3'd1) begin
                v.rs2 = ONES;
            end
            v.exp  = ref_result(v.op, v.word, v.rs1, v.rs2);
            vec[i] = v;
        end
    endtask

    // --------------------------------------------------
    // Operation sequences, called on a falling edge
    // --------------------------------------------------

    task automatic run_op(input vec_t v, input int idx);
        int cycles;
        req    = make_req(v.op, v.word, v.rs1, v.rs2);
        valid  = 1'b1;
        cycles = 0;
        @(negedge g_clk);
        while (!ready && cycles < READY_LIMIT) begin
            @(negedge g_clk);
            cycles++;
        end
        if (!ready) begin
            timeouts++;
            $display("Entry %0d never raised ready within %0d cycles", idx, READY_LIMIT);
        end else begin
            check_value($sformatf("entry %0d rd", idx), rd, v.exp);
            repeat (HOLD_CYCLES) begin
                @(negedge g_clk);
                check_value($sformatf("entry %0d ready held", idx),
                            mdu_pkg::xlen_t'(ready), 64'h1);
                check_value($sformatf("entry %0d rd held", idx), rd, v.exp);
            end
        end
        valid = 1'b0;
        flush = 1'b1;
        @(negedge g_clk);
        flush = 1'b0;
        check_value($sformatf("entry %0d ready after flush", idx),
                    mdu_pkg::xlen_t'(ready), 64'h0);
        @(negedge g_clk);
    endtask

    task automatic flush_mid_op();
        req   = make_req(OP_DIV, 0, 64'h7654_3210_FEDC_BA98, 64'h0000_0000_0001_2345);
        valid = 1'b1;
        repeat (10) @(negedge g_clk);
        check_value("ready mid divide", mdu_pkg::xlen_t'(ready), 64'h0);
        valid = 1'b0;
        flush = 1'b1;
        @(negedge g_clk);
        flush = 1'b0;
        check_value("ready after mid flush", mdu_pkg::xlen_t'(ready), 64'h0);
        // Past the point where the abandoned divide would have finished
        repeat (`MDU_XLEN + 8) @(negedge g_clk);
        check_value("ready idle after flush", mdu_pkg::xlen_t'(ready), 64'h0);
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------

    initial begin
        arst_n = 1'b0;
        valid  = 1'b0;
        flush  = 1'b0;
        req    = '0;
        load_fixed();
        fill_random();
        repeat (3) @(negedge g_clk);
        arst_n = 1'b1;
        check_value("ready after reset", mdu_pkg::xlen_t'(ready), 64'h0);
        @(negedge g_clk);
        for (int i = 0; i < NUM_VEC; i++) begin
            run_op(vec[i], i);
        end
        flush_mid_op();
        run_op(vec[3], 3);   // Unit must recover after an abandoned divide
        $display("Checks done: %0d mismatches, %0d ready timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the test sequence did not complete within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
verilog/mdu_pkg.sv
verilog/mdu_ctrl.sv
verilog/mdu_mul_datapath.sv
verilog/mdu_div_datapath.sv
verilog/core_pipe_exec_mdu.sv
verif/tb_mdu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the MDU testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_mdu -o tb_mdu \
    > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_mdu > "$SIM_LOG" 2>&1 \
    || { cat "$SIM_LOG"; echo "Simulation run returned an error"; exit 1; }

cat "$SIM_LOG"

grep -q "Simulation finished: FAIL" "$SIM_LOG" \
    && { echo "Testbench reported failure"; exit 1; }

grep -q "Simulation finished: PASS" "$SIM_LOG" \
    || { echo "No result line found in $SIM_LOG"; exit 1; }

exit 0
